// ==== rtl/mem_stage_params.svh ====
// Width and depth macros of the data-memory stage, included by the package and the RTL blocks
`ifndef MEM_STAGE_PARAMS_SVH
`define MEM_STAGE_PARAMS_SVH

// Address widths
`define VADDR_W 32
`define PADDR_W 20
`define PAGE_BITS 12
`define PPN_W (`PADDR_W - `PAGE_BITS)
`define VPN_W (`VADDR_W - `PAGE_BITS)

// Data widths
`define WORD_W 32
`define LINE_W 128

// Table and buffer sizes
`define TLB_ENTRIES 4
`define SB_DEPTH 4

`endif

// ==== rtl/mem_stage_pkg.sv ====
// Shared types of the data-memory stage, imported by each RTL block that needs them
`include "mem_stage_params.svh"

package mem_stage_pkg;

	typedef logic [`VADDR_W-1:0] vaddr_t;
	typedef logic [`PADDR_W-1:0] paddr_t;
	typedef logic [`VPN_W-1:0] vpn_t;
	typedef logic [`PPN_W-1:0] ppn_t;

	typedef logic [`WORD_W-1:0] word_t;
	typedef logic [`LINE_W-1:0] line_t;

	// One extra bit so a full buffer can be told from an empty one
	typedef logic [$clog2(`SB_DEPTH):0] sb_count_t;

	// Load controller states
	typedef enum logic [1:0] {
		IDLE,
		DRAIN_WAIT,
		MEM_WAIT,
		RESPOND
	} load_state_e;

endpackage

// ==== rtl/mem_req_if.sv ====
// Translated and checked request passed from the data TLB to the store buffer and load controller
`timescale 1ns/1ps

interface mem_req_if;
	import mem_stage_pkg::*;

	logic valid;
	logic store;
	logic byte_access;
	paddr_t paddr;
	word_t wdata;

	modport tlb (
		output valid,
		output store,
		output byte_access,
		output paddr,
		output wdata
	);

	modport user (
		input valid,
		input store,
		input byte_access,
		input paddr,
		input wdata
	);

endinterface

// ==== rtl/dtlb.sv ====
// Data TLB that maps virtual pages to physical pages and flags faults and misaligned accesses
`timescale 1ns/1ps
`include "mem_stage_params.svh"

module dtlb (
	input  logic                  clk_i,
	input  logic                  rst_n_i,
	input  logic                  req_valid_i,
	input  logic                  req_store_i,
	input  logic                  req_byte_i,
	input  mem_stage_pkg::vaddr_t req_vaddr_i,
	input  mem_stage_pkg::word_t  req_wdata_i,
	input  logic                  stall_i,
	input  logic                  tlb_write_i,
	input  mem_stage_pkg::vpn_t   tlb_vpn_i,
	input  mem_stage_pkg::ppn_t   tlb_ppn_i,
	mem_req_if.tlb                req,
	output logic                  fault_o,
	output logic                  misalign_o
);
	import mem_stage_pkg::*;

	localparam int IDX_W = $clog2(`TLB_ENTRIES);

	logic [`TLB_ENTRIES-1:0] entry_valid;
	vpn_t entry_vpn [`TLB_ENTRIES];
	ppn_t entry_ppn [`TLB_ENTRIES];
	logic [IDX_W-1:0] wr_ptr;
	logic [IDX_W-1:0] wr_idx;
	logic wr_match;
	logic hit;
	ppn_t hit_ppn;
	logic unaligned;
	logic accept;
	logic dup_vpn;

	// An existing vpn is rewritten in place, otherwise the round-robin slot is used
	always_comb begin
		wr_match = 1'b0;
		wr_idx = wr_ptr;
		hit = 1'b0;
		hit_ppn = '0;
		for (int i = 0; i < `TLB_ENTRIES; i++) begin
			if (entry_valid[i] && entry_vpn[i] == tlb_vpn_i) begin
				wr_match = 1'b1;
				wr_idx = IDX_W'(i);
			end
			if (entry_valid[i] && entry_vpn[i] == req_vaddr_i[`VADDR_W-1:`PAGE_BITS]) begin
				hit = 1'b1;
				hit_ppn = entry_ppn[i];
			end
		end
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			entry_valid <= '0;
			wr_ptr <= '0;
		end else if (tlb_write_i) begin
			entry_valid[wr_idx] <= 1'b1;
			if (!wr_match)
				wr_ptr <= wr_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk_i) begin
		if (tlb_write_i) begin
			entry_vpn[wr_idx] <= tlb_vpn_i;
			entry_ppn[wr_idx] <= tlb_ppn_i;
		end
	end

	// Byte accesses are always aligned
	assign unaligned = !req_byte_i && (req_vaddr_i[1:0] != 2'b00);
	assign accept = req_valid_i && !stall_i;

	assign req.valid = req_valid_i && hit && !unaligned;
	assign req.store = req_store_i;
	assign req.byte_access = req_byte_i;
	assign req.paddr = {hit_ppn, req_vaddr_i[`PAGE_BITS-1:0]};
	assign req.wdata = req_wdata_i;

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			fault_o <= 1'b0;
			misalign_o <= 1'b0;
		end else begin
			fault_o <= accept && !hit;
			misalign_o <= accept && hit && unaligned;
		end
	end

	always_comb begin
		dup_vpn = 1'b0;
		for (int i = 0; i < `TLB_ENTRIES; i++)
			for (int j = i + 1; j < `TLB_ENTRIES; j++)
				if (entry_valid[i] && entry_valid[j] && entry_vpn[i] == entry_vpn[j])
					dup_vpn = 1'b1;
	end

	assert property (@(posedge clk_i) disable iff (!rst_n_i) !dup_vpn)
		else $error("dtlb: two valid entries hold the same vpn");

endmodule

// ==== rtl/store_buffer.sv ====
// Store FIFO that holds stores until commit, forwards them to loads and drains them to memory
`timescale 1ns/1ps
`include "mem_stage_params.svh"

module store_buffer (
	input  logic                  clk_i,
	input  logic                  rst_n_i,
	mem_req_if.user               req,
	input  logic                  stall_i,
	input  logic                  commit_i,
	output logic                  full_o,
	output logic                  fwd_hit_o,
	output mem_stage_pkg::word_t  fwd_data_o,
	output logic                  overlap_o,
	output logic                  mem_write_enable_o,
	output logic                  mem_write_byte_o,
	output mem_stage_pkg::paddr_t mem_write_addr_o,
	output mem_stage_pkg::word_t  mem_write_data_o
);
	import mem_stage_pkg::*;

	localparam int PTR_W = $clog2(`SB_DEPTH);

	paddr_t sb_addr [`SB_DEPTH];
	word_t sb_data [`SB_DEPTH];
	logic [`SB_DEPTH-1:0] sb_byte;
	logic [PTR_W-1:0] head;
	logic [PTR_W-1:0] tail;
	logic [PTR_W-1:0] idx;
	sb_count_t count;
	logic push;
	logic is_load;
	logic found;
	logic found_exact;
	word_t found_data;

	assign push = req.valid && req.store && !stall_i;
	assign is_load = req.valid && !req.store;
	assign full_o = (count == sb_count_t'(`SB_DEPTH));

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			head <= '0;
			tail <= '0;
			count <= '0;
			mem_write_enable_o <= 1'b0;
		end else begin
			if (push)
				tail <= tail + 1'b1;
			if (commit_i)
				head <= head + 1'b1;
			count <= count + sb_count_t'(push) - sb_count_t'(commit_i);
			mem_write_enable_o <= commit_i;
		end
	end

	// Oldest entry leaves on commit and reaches memory one cycle later
	always_ff @(posedge clk_i) begin
		if (push) begin
			sb_addr[tail] <= req.paddr;
			sb_data[tail] <= req.wdata;
			sb_byte[tail] <= req.byte_access;
		end
		if (commit_i) begin
			mem_write_addr_o <= sb_addr[head];
			mem_write_data_o <= sb_data[head];
			mem_write_byte_o <= sb_byte[head];
		end
	end

	// Walked oldest to youngest, so the youngest same-word store decides
	always_comb begin
		found = 1'b0;
		found_exact = 1'b0;
		found_data = '0;
		idx = head;
		for (int i = 0; i < `SB_DEPTH; i++) begin
			if (sb_count_t'(i) < count &&
			    sb_addr[idx][`PADDR_W-1:2] == req.paddr[`PADDR_W-1:2]) begin
				found = 1'b1;
				found_exact = (sb_addr[idx] == req.paddr) && (sb_byte[idx] == req.byte_access);
				found_data = sb_data[idx];
			end
			idx = idx + 1'b1;
		end
	end

	assign fwd_hit_o = is_load && found && found_exact;
	assign overlap_o = is_load && found && !found_exact;
	assign fwd_data_o = req.byte_access ? {{(`WORD_W-8){1'b0}}, found_data[7:0]} : found_data;

	assert property (@(posedge clk_i) disable iff (!rst_n_i) commit_i |-> count != '0)
		else $error("store_buffer: commit while empty");

	assert property (@(posedge clk_i) disable iff (!rst_n_i) push |-> !full_o)
		else $error("store_buffer: push while full");

endmodule

// ==== rtl/load_miss_ctrl.sv ====
// Load controller that raises the stall, fetches missing lines and returns load data
`timescale 1ns/1ps
`include "mem_stage_params.svh"

module load_miss_ctrl (
	input  logic                  clk_i,
	input  logic                  rst_n_i,
	mem_req_if.user               req,
	input  logic                  sb_full_i,
	input  logic                  fwd_hit_i,
	input  mem_stage_pkg::word_t  fwd_data_i,
	input  logic                  overlap_i,
	input  logic                  mem_data_ready_i,
	input  mem_stage_pkg::line_t  mem_data_i,
	input  mem_stage_pkg::paddr_t mem_addr_i,
	output logic                  stall_o,
	output logic                  mem_read_o,
	output mem_stage_pkg::paddr_t mem_read_addr_o,
	output logic                  load_valid_o,
	output mem_stage_pkg::word_t  load_data_o
);
	import mem_stage_pkg::*;

	load_state_e state;
	load_state_e state_next;
	paddr_t pend_addr;
	logic pend_byte;
	logic is_load;
	logic load_accept;
	logic line_ready;
	word_t line_word;
	word_t line_data;

	assign is_load = req.valid && !req.store;
	assign load_accept = is_load && !stall_o;
	assign mem_read_o = (state == MEM_WAIT);
	assign mem_read_addr_o = {pend_addr[`PADDR_W-1:4], 4'b0000};
	assign line_ready = mem_read_o && mem_data_ready_i && (mem_addr_i == mem_read_addr_o);

	// Full buffer holds stores, a partial overlap holds loads until it drains
	always_comb begin
		if (state == MEM_WAIT || state == RESPOND)
			stall_o = 1'b1;
		else
			stall_o = (req.valid && req.store && sb_full_i) || (is_load && overlap_i);
	end

	always_comb begin
		state_next = state;
		case (state)
			IDLE, DRAIN_WAIT: begin
				if (load_accept && !fwd_hit_i)
					state_next = MEM_WAIT;
				else if (is_load && overlap_i)
					state_next = DRAIN_WAIT;
				else
					state_next = IDLE;
			end
			MEM_WAIT: begin
				if (line_ready)
					state_next = RESPOND;
			end
			default: state_next = IDLE;
		endcase
	end

	assign line_word = mem_data_i[pend_addr[3:2]*`WORD_W +: `WORD_W];
	assign line_data = pend_byte ? {{(`WORD_W-8){1'b0}}, line_word[pend_addr[1:0]*8 +: 8]} :
	                               line_word;

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state <= IDLE;
			load_valid_o <= 1'b0;
		end else begin
			state <= state_next;
			load_valid_o <= (load_accept && fwd_hit_i) || line_ready;
		end
	end

	always_ff @(posedge clk_i) begin
		if (load_accept) begin
			pend_addr <= req.paddr;
			pend_byte <= req.byte_access;
		end
		if (load_accept && fwd_hit_i)
			load_data_o <= fwd_data_i;
		else if (line_ready)
			load_data_o <= line_data;
	end

	assert property (@(posedge clk_i) disable iff (!rst_n_i)
		mem_read_o && !line_ready |=> mem_read_o && $stable(mem_read_addr_o))
		else $error("load_miss_ctrl: read request dropped before its line returned");

endmodule

// ==== rtl/mem_stage.sv ====
// Top level of the data-memory stage joining the TLB, store buffer and load controller
`timescale 1ns/1ps

module mem_stage (
	input  logic                  clk_i,
	input  logic                  rst_n_i,
	input  logic                  req_valid_i,
	input  logic                  req_store_i,
	input  logic                  req_byte_i,
	input  mem_stage_pkg::vaddr_t req_vaddr_i,
	input  mem_stage_pkg::word_t  req_wdata_i,
	input  logic                  tlb_write_i,
	input  mem_stage_pkg::vpn_t   tlb_vpn_i,
	input  mem_stage_pkg::ppn_t   tlb_ppn_i,
	input  logic                  commit_i,
	input  logic                  mem_data_ready_i,
	input  mem_stage_pkg::line_t  mem_data_i,
	input  mem_stage_pkg::paddr_t mem_addr_i,
	output logic                  stall_o,
	output logic                  sb_full_o,
	output logic                  fault_o,
	output logic                  misalign_o,
	output logic                  load_valid_o,
	output mem_stage_pkg::word_t  load_data_o,
	output logic                  mem_read_o,
	output mem_stage_pkg::paddr_t mem_read_addr_o,
	output logic                  mem_write_enable_o,
	output logic                  mem_write_byte_o,
	output mem_stage_pkg::paddr_t mem_write_addr_o,
	output mem_stage_pkg::word_t  mem_write_data_o
);
	import mem_stage_pkg::*;

	logic fwd_hit;
	word_t fwd_data;
	logic overlap;

	mem_req_if req_if ();

	dtlb dtlb_inst (
		.clk_i       (clk_i),
		.rst_n_i     (rst_n_i),
		.req_valid_i (req_valid_i),
		.req_store_i (req_store_i),
		.req_byte_i  (req_byte_i),
		.req_vaddr_i (req_vaddr_i),
		.req_wdata_i (req_wdata_i),
		.stall_i     (stall_o),
		.tlb_write_i (tlb_write_i),
		.tlb_vpn_i   (tlb_vpn_i),
		.tlb_ppn_i   (tlb_ppn_i),
		.req         (req_if),
		.fault_o     (fault_o),
		.misalign_o  (misalign_o)
	);

	store_buffer store_buffer_inst (
		.clk_i              (clk_i),
		.rst_n_i            (rst_n_i),
		.req                (req_if),
		.stall_i            (stall_o),
		.commit_i           (commit_i),
		.full_o             (sb_full_o),
		.fwd_hit_o          (fwd_hit),
		.fwd_data_o         (fwd_data),
		.overlap_o          (overlap),
		.mem_write_enable_o (mem_write_enable_o),
		.mem_write_byte_o   (mem_write_byte_o),
		.mem_write_addr_o   (mem_write_addr_o),
		.mem_write_data_o   (mem_write_data_o)
	);

	load_miss_ctrl load_miss_ctrl_inst (
		.clk_i            (clk_i),
		.rst_n_i          (rst_n_i),
		.req              (req_if),
		.sb_full_i        (sb_full_o),
		.fwd_hit_i        (fwd_hit),
		.fwd_data_i       (fwd_data),
		.overlap_i        (overlap),
		.mem_data_ready_i (mem_data_ready_i),
		.mem_data_i       (mem_data_i),
		.mem_addr_i       (mem_addr_i),
		.stall_o          (stall_o),
		.mem_read_o       (mem_read_o),
		.mem_read_addr_o  (mem_read_addr_o),
		.load_valid_o     (load_valid_o),
		.load_data_o      (load_data_o)
	);

endmodule

// ==== verification/mem_stage_tb.sv ====
// Directed testbench of the data-memory stage with a line memory model; run it as the simulation top
`timescale 1ns/1ps

module mem_stage_tb;
	import mem_stage_pkg::*;

	localparam int CLK_PERIOD = 20;
	localparam int RESET_CYCLES = 5;
	localparam int READ_LATENCY = 3;
	localparam int WAIT_LIMIT = 40;
	localparam int NUM_TESTS = 6;
	localparam int TEST_CYCLES = 120;
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_TESTS * TEST_CYCLES + 100;
	localparam int PA_W = $bits(paddr_t);

	typedef logic [PA_W-3:0] widx_t;

	logic clk_i;
	logic rst_n_i;
	logic req_valid_i;
	logic req_store_i;
	logic req_byte_i;
	vaddr_t req_vaddr_i;
	word_t req_wdata_i;
	logic tlb_write_i;
	vpn_t tlb_vpn_i;
	ppn_t tlb_ppn_i;
	logic commit_i;
	logic mem_data_ready_i = 1'b0;
	line_t mem_data_i = '0;
	paddr_t mem_addr_i = '0;
	logic stall_o;
	logic sb_full_o;
	logic fault_o;
	logic misalign_o;
	logic load_valid_o;
	word_t load_data_o;
	logic mem_read_o;
	paddr_t mem_read_addr_o;
	logic mem_write_enable_o;
	logic mem_write_byte_o;
	paddr_t mem_write_addr_o;
	word_t mem_write_data_o;

	int err_count = 0;
	int check_count = 0;
	int test_count = 0;
	int read_cycles = 0;
	int read_wait = 0;
	paddr_t last_read_addr = '0;
	logic [15:0] lfsr = 16'd65;
	word_t mem_writes [widx_t];

	mem_stage mem_stage_inst (.*);

	initial begin
		clk_i = 1'b0;
		forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
	end

	// Fibonacci LFSR with taps x^16 + x^14 + x^13 + x^11
	function automatic word_t rand_bits(input int n);
		word_t r;
		logic fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr = {lfsr[14:0], fb};
			r = {r[30:0], fb};
		end
		return r;
	endfunction

	function automatic word_t mem_word(input widx_t widx);
		if (mem_writes.exists(widx))
			return mem_writes[widx];
		return 32'hC0DE0000 + {14'd0, widx};
	endfunction

	function automatic word_t word_at(input paddr_t addr);
		return mem_word(addr[PA_W-1:2]);
	endfunction

	function automatic line_t mem_line(input paddr_t addr);
		line_t line;
		for (int w = 0; w < 4; w++)
			line[w*32 +: 32] = mem_word({addr[PA_W-1:4], 2'(w)});
		return line;
	endfunction

	// Memory model that records writes and answers a read after READ_LATENCY cycles
	always @(negedge clk_i) begin : mem_model
		widx_t widx;
		word_t cur;
		if (mem_write_enable_o) begin
			widx = mem_write_addr_o[PA_W-1:2];
			cur = mem_word(widx);
			if (mem_write_byte_o)
				cur[mem_write_addr_o[1:0]*8 +: 8] = mem_write_data_o[7:0];
			else
				cur = mem_write_data_o;
			mem_writes[widx] = cur;
		end
		if (mem_data_ready_i) begin
			mem_data_ready_i = 1'b0;
			read_wait = 0;
		end else if (mem_read_o) begin
			read_cycles++;
			read_wait++;
			last_read_addr = mem_read_addr_o;
			if (read_wait == READ_LATENCY) begin
				mem_addr_i = mem_read_addr_o;
				mem_data_i = mem_line(mem_read_addr_o);
				mem_data_ready_i = 1'b1;
			end
		end
	end

	task automatic check_equal(input string name, input word_t actual, input word_t expected);
		check_count++;
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
			err_count++;
		end
	endtask

	task automatic finish_test(input string name, input int start_errs);
		test_count++;
		$display("%s: done, %0d errors", name, err_count - start_errs);
	endtask

	task automatic write_tlb(input vpn_t vpn, input ppn_t ppn);
		@(negedge clk_i);
		tlb_write_i = 1'b1;
		tlb_vpn_i = vpn;
		tlb_ppn_i = ppn;
		@(negedge clk_i);
		tlb_write_i = 1'b0;
	endtask

	task automatic drive_req(input logic store, input logic is_byte, input vaddr_t vaddr,
	                         input word_t wdata);
		@(negedge clk_i);
		req_valid_i = 1'b1;
		req_store_i = store;
		req_byte_i = is_byte;
		req_vaddr_i = vaddr;
		req_wdata_i = wdata;
	endtask

	task automatic release_req();
		@(negedge clk_i);
		req_valid_i = 1'b0;
	endtask

	// Holds the request until stall_o is low, then lets one rising edge accept it
	task automatic issue(input logic store, input logic is_byte, input vaddr_t vaddr,
	                     input word_t wdata);
		int waited;
		drive_req(store, is_byte, vaddr, wdata);
		#1;
		waited = 0;
		while (stall_o && waited < WAIT_LIMIT) begin
			@(negedge clk_i);
			#1;
			waited++;
		end
		if (stall_o) begin
			$display("Request at vaddr %h stayed stalled for %0d cycles", vaddr, WAIT_LIMIT);
			err_count++;
		end
		release_req();
	endtask

	task automatic wait_load(output word_t data, output int cycles);
		cycles = 0;
		while (!load_valid_o && cycles < WAIT_LIMIT) begin
			@(negedge clk_i);
			cycles++;
		end
		if (!load_valid_o) begin
			$display("No load_valid_o pulse within %0d cycles", WAIT_LIMIT);
			err_count++;
		end
		data = load_data_o;
	endtask

	task automatic commit_one(input paddr_t addr, input word_t data, input logic is_byte);
		@(negedge clk_i);
		commit_i = 1'b1;
		@(negedge clk_i);
		commit_i = 1'b0;
		check_equal("mem_write_enable_o", 32'(mem_write_enable_o), 32'd1);
		check_equal("mem_write_addr_o", 32'(mem_write_addr_o), 32'(addr));
		check_equal("mem_write_data_o", mem_write_data_o, data);
		check_equal("mem_write_byte_o", 32'(mem_write_byte_o), 32'(is_byte));
	endtask

	task automatic fault_then_map();
		int start_errs;
		int reads_before;
		word_t data;
		int cycles;
		start_errs = err_count;
		reads_before = read_cycles;
		issue(1'b0, 1'b0, 32'h0002_0100, '0);
		check_equal("fault_o", 32'(fault_o), 32'd1);
		@(negedge clk_i);
		check_equal("fault_o", 32'(fault_o), 32'd0);
		repeat (4) @(negedge clk_i);
		check_equal("mem_read_o cycles", 32'(read_cycles), 32'(reads_before));
		write_tlb(20'h00020, 8'h07);
		issue(1'b0, 1'b0, 32'h0002_0100, '0);
		check_equal("fault_o", 32'(fault_o), 32'd0);
		wait_load(data, cycles);
		check_equal("load_data_o", data, 32'hC0DE0000 + 32'h1C40);
		finish_test("fault_then_map", start_errs);
	endtask

	task automatic misalign_word_only();
		int start_errs;
		word_t data;
		word_t w;
		int cycles;
		start_errs = err_count;
		issue(1'b0, 1'b0, 32'h0001_0042, '0);
		check_equal("misalign_o", 32'(misalign_o), 32'd1);
		@(negedge clk_i);
		check_equal("misalign_o", 32'(misalign_o), 32'd0);
		check_equal("mem_read_o", 32'(mem_read_o), 32'd0);
		issue(1'b0, 1'b1, 32'h0001_0042, '0);
		check_equal("misalign_o", 32'(misalign_o), 32'd0);
		wait_load(data, cycles);
		w = word_at(20'h05042);
		check_equal("load_data_o", data, {24'd0, w[23:16]});
		finish_test("misalign_word_only", start_errs);
	endtask

	task automatic forward_store();
		int start_errs;
		int reads_before;
		word_t wdata;
		word_t data;
		int cycles;
		start_errs = err_count;
		wdata = rand_bits(32);
		issue(1'b1, 1'b0, 32'h0001_0080, wdata);
		reads_before = read_cycles;
		issue(1'b0, 1'b0, 32'h0001_0080, '0);
		wait_load(data, cycles);
		check_equal("load_valid_o delay", 32'(cycles), 32'd0);
		check_equal("load_data_o", data, wdata);
		check_equal("mem_read_o cycles", 32'(read_cycles), 32'(reads_before));
		commit_one(20'h05080, wdata, 1'b0);
		finish_test("forward_store", start_errs);
	endtask

	task automatic miss_word_and_byte();
		int start_errs;
		word_t data;
		word_t w;
		int cycles;
		start_errs = err_count;
		issue(1'b0, 1'b0, 32'h0001_0234, '0);
		wait_load(data, cycles);
		check_equal("mem_read_addr_o", 32'(last_read_addr), 32'h05230);
		check_equal("load_data_o", data, word_at(20'h05234));
		issue(1'b0, 1'b1, 32'h0001_0237, '0);
		wait_load(data, cycles);
		w = word_at(20'h05237);
		check_equal("load_data_o", data, {24'd0, w[31:24]});
		finish_test("miss_word_and_byte", start_errs);
	endtask

	task automatic fill_and_drain();
		int start_errs;
		vaddr_t addrs [5];
		logic flags [5];
		word_t wdata [5];
		start_errs = err_count;
		addrs = '{32'h0001_0300, 32'h0001_0305, 32'h0001_0308, 32'h0001_030E, 32'h0001_0310};
		flags = '{1'b0, 1'b1, 1'b0, 1'b1, 1'b0};
		for (int i = 0; i < 5; i++)
			wdata[i] = rand_bits(32);
		for (int i = 0; i < 4; i++)
			issue(1'b1, flags[i], addrs[i], wdata[i]);
		check_equal("sb_full_o", 32'(sb_full_o), 32'd1);
		drive_req(1'b1, flags[4], addrs[4], wdata[4]);
		#1;
		check_equal("stall_o", 32'(stall_o), 32'd1);
		@(negedge clk_i);
		#1;
		check_equal("stall_o", 32'(stall_o), 32'd1);
		commit_one({8'h05, addrs[0][11:0]}, wdata[0], flags[0]);
		#1;
		check_equal("stall_o", 32'(stall_o), 32'd0);
		release_req();
		check_equal("sb_full_o", 32'(sb_full_o), 32'd1);
		for (int i = 1; i < 5; i++)
			commit_one({8'h05, addrs[i][11:0]}, wdata[i], flags[i]);
		check_equal("sb_full_o", 32'(sb_full_o), 32'd0);
		finish_test("fill_and_drain", start_errs);
	endtask

	task automatic overlap_drain();
		int start_errs;
		int reads_before;
		word_t wdata;
		word_t expected;
		word_t data;
		int cycles;
		start_errs = err_count;
		wdata = rand_bits(32);
		issue(1'b1, 1'b1, 32'h0001_0401, wdata);
		reads_before = read_cycles;
		drive_req(1'b0, 1'b0, 32'h0001_0400, '0);
		#1;
		check_equal("stall_o", 32'(stall_o), 32'd1);
		repeat (2) @(negedge clk_i);
		#1;
		check_equal("stall_o", 32'(stall_o), 32'd1);
		check_equal("mem_read_o cycles", 32'(read_cycles), 32'(reads_before));
		commit_one(20'h05401, wdata, 1'b1);
		release_req();
		wait_load(data, cycles);
		// Byte 1 of the word comes from the drained store
		expected = 32'hC0DE0000 + 32'h1500;
		expected[15:8] = wdata[7:0];
		check_equal("load_data_o", data, expected);
		finish_test("overlap_drain", start_errs);
	endtask

	initial begin
		rst_n_i = 1'b0;
		req_valid_i = 1'b0;
		req_store_i = 1'b0;
		req_byte_i = 1'b0;
		req_vaddr_i = '0;
		req_wdata_i = '0;
		tlb_write_i = 1'b0;
		tlb_vpn_i = '0;
		tlb_ppn_i = '0;
		commit_i = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_i);
		@(negedge clk_i);
		check_equal("outputs in reset", 32'({load_valid_o, fault_o, misalign_o, mem_read_o,
			mem_write_enable_o, stall_o, sb_full_o}), 32'd0);
		rst_n_i = 1'b1;
		write_tlb(20'h00010, 8'h05);
		fault_then_map();
		misalign_word_only();
		forward_store();
		miss_word_and_byte();
		fill_and_drain();
		overlap_drain();
		$display("%0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
		if (err_count == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_i);
		$display("Watchdog expired after %0d cycles before the tests finished", WATCHDOG_CYCLES);
		$display("TESTS FAILED");
		$finish;
	end

endmodule

// ==== project.f ====
+incdir+rtl
rtl/mem_stage_pkg.sv
rtl/mem_req_if.sv
rtl/dtlb.sv
rtl/store_buffer.sv
rtl/load_miss_ctrl.sv
rtl/mem_stage.sv
verification/mem_stage_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= mem_stage_tb
FILELIST ?= project.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

SOURCES := $(wildcard rtl/*.sv rtl/*.svh verification/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
